// ==== logic/mac_grp_reg_pkg.sv ====
package mac_grp_reg_pkg;

   // ======================================================================
   // bus and register file geometry
   // ======================================================================
   localparam int unsigned data_width    = 32;
   localparam int unsigned num_regs      = 11;
   localparam int unsigned reg_idx_width = 4;
   localparam int unsigned paddr_width   = 8;

   typedef logic [data_width-1:0]    data_t;
   typedef logic [reg_idx_width-1:0] reg_idx_t;

   // word index of each register
   localparam reg_idx_t idx_control              = 4'd0;
   localparam reg_idx_t idx_rx_pkts_stored       = 4'd1;
   localparam reg_idx_t idx_rx_pkts_dropped_full = 4'd2;
   localparam reg_idx_t idx_rx_pkts_dropped_bad  = 4'd3;
   localparam reg_idx_t idx_rx_pkts_dequeued     = 4'd4;
   localparam reg_idx_t idx_rx_bytes_pushed      = 4'd5;
   localparam reg_idx_t idx_rx_pkts_in_queue     = 4'd6;
   localparam reg_idx_t idx_tx_pkts_enqueued     = 4'd7;
   localparam reg_idx_t idx_tx_pkts_sent         = 4'd8;
   localparam reg_idx_t idx_tx_bytes_pushed      = 4'd9;
   localparam reg_idx_t idx_tx_pkts_in_queue     = 4'd10;

   // ======================================================================
   // control register layout
   // ======================================================================
   localparam int unsigned bit_rx_queue_disable = 0;
   localparam int unsigned bit_tx_queue_disable = 1;
   localparam int unsigned bit_reset_mac        = 2;
   localparam int unsigned bit_dis_jumbo_tx     = 3;
   localparam int unsigned bit_dis_jumbo_rx     = 4;
   localparam int unsigned bit_dis_crc_check    = 5;
   localparam int unsigned bit_dis_crc_gen      = 6;
   localparam int unsigned bit_disable_rx       = 7;
   localparam int unsigned bit_disable_tx       = 8;

   // read value for holes in the map
   localparam data_t bad_addr_data = 32'hdead_beef;

   // mac reset held this long after block reset
   localparam int unsigned reset_stretch_cycles = 4;

   typedef struct packed {
      logic                   psel;
      logic                   penable;
      logic                   pwrite;
      logic [paddr_width-1:0] paddr;
      data_t                  pwdata;
   } apb_req_t;

   typedef struct packed {
      logic reset_mac;
      logic disable_crc_check;
      logic disable_crc_gen;
      logic enable_jumbo_rx;
      logic enable_jumbo_tx;
      logic rx_mac_en;
      logic tx_mac_en;
      logic rx_queue_en;
      logic tx_queue_en;
   } mac_ctrl_t;

endpackage

// ==== logic/mac_grp_stat_pkg.sv ====
package mac_grp_stat_pkg;

   // ======================================================================
   // packet event inputs
   // ======================================================================
   localparam int unsigned byte_cnt_width = 12;

   typedef struct packed {
      logic                      pkt_good;
      logic                      pkt_bad;
      logic                      pkt_dropped;
      logic                      pkt_pulled;
      logic [byte_cnt_width-1:0] pkt_byte_cnt;
   } rx_events_t;

   typedef struct packed {
      logic                      pkt_sent;
      logic                      pkt_stored;
      logic [byte_cnt_width-1:0] pkt_byte_cnt;
   } tx_events_t;

   // ======================================================================
   // pending deltas between scanner visits
   // ======================================================================
   // sized for a few events per lap at most
   localparam int unsigned cnt_delta_width   = 8;
   localparam int unsigned byte_delta_width  = 16;
   localparam int unsigned queue_delta_width = 6;

   typedef logic [cnt_delta_width-1:0]          cnt_delta_t;
   typedef logic [byte_delta_width-1:0]         byte_delta_t;
   typedef logic signed [queue_delta_width-1:0] queue_delta_t;

   // one field per statistics register, control has none
   typedef struct packed {
      cnt_delta_t   rx_pkts_stored;
      cnt_delta_t   rx_pkts_dropped_full;
      cnt_delta_t   rx_pkts_dropped_bad;
      cnt_delta_t   rx_pkts_dequeued;
      byte_delta_t  rx_bytes_pushed;
      queue_delta_t rx_pkts_in_queue;
      cnt_delta_t   tx_pkts_enqueued;
      cnt_delta_t   tx_pkts_sent;
      byte_delta_t  tx_bytes_pushed;
      queue_delta_t tx_pkts_in_queue;
   } stat_deltas_t;

endpackage

// ==== logic/stat_delta_accum.sv ====
module stat_delta_accum #(
   parameter type delta_t = logic [7:0]
) (
   input  logic   clk,
   input  logic   reset,
   input  delta_t inc,
   input  logic   commit,
   output delta_t delta
);

   // on commit the held value goes to the register file and this
   // cycle's increment starts the next lap, so nothing is lost
   always_ff @(posedge clk) begin
      if (reset)
         delta <= '0;
      else if (commit)
         delta <= inc;
      else
         delta <= delta + inc;
   end

endmodule

// ==== logic/stat_reg_file.sv ====
module stat_reg_file (
   input  logic                      clk,
   input  logic                      we,
   input  mac_grp_reg_pkg::reg_idx_t idx,
   input  mac_grp_reg_pkg::data_t    wdata,
   output mac_grp_reg_pkg::data_t    rdata
);

   mac_grp_reg_pkg::data_t mem [mac_grp_reg_pkg::num_regs];

   always_ff @(posedge clk) begin
      if (we)
         mem[idx] <= wdata;
   end

   // read is combinational so the scanner can update in one cycle
   assign rdata = mem[idx];

endmodule

// ==== logic/stat_delta_bank.sv ====
module stat_delta_bank (
   input  logic                                 clk,
   input  logic                                 reset,
   input  mac_grp_stat_pkg::rx_events_t         rx_events,
   input  mac_grp_stat_pkg::tx_events_t         tx_events,
   input  logic [mac_grp_reg_pkg::num_regs-1:0] commit,
   output mac_grp_stat_pkg::stat_deltas_t       deltas
);

   typedef mac_grp_stat_pkg::cnt_delta_t   cnt_t;
   typedef mac_grp_stat_pkg::byte_delta_t  byte_t;
   typedef mac_grp_stat_pkg::queue_delta_t queue_t;

   mac_grp_stat_pkg::stat_deltas_t incs;

   // ======================================================================
   // per-cycle increments
   // ======================================================================
   always_comb begin
      incs.rx_pkts_stored       = cnt_t'(rx_events.pkt_good);
      incs.rx_pkts_dropped_full = cnt_t'(rx_events.pkt_dropped);
      incs.rx_pkts_dropped_bad  = cnt_t'(rx_events.pkt_bad);
      incs.rx_pkts_dequeued     = cnt_t'(rx_events.pkt_pulled);
      incs.rx_bytes_pushed      = rx_events.pkt_pulled ? byte_t'(rx_events.pkt_byte_cnt) : '0;
      // in and out together cancel
      incs.rx_pkts_in_queue = queue_t'(rx_events.pkt_good) - queue_t'(rx_events.pkt_pulled);
      incs.tx_pkts_enqueued = cnt_t'(tx_events.pkt_stored);
      incs.tx_pkts_sent     = cnt_t'(tx_events.pkt_sent);
      incs.tx_bytes_pushed  = tx_events.pkt_stored ? byte_t'(tx_events.pkt_byte_cnt) : '0;
      incs.tx_pkts_in_queue = queue_t'(tx_events.pkt_stored) - queue_t'(tx_events.pkt_sent);
   end

   // ======================================================================
   // accumulators, none for the control slot
   // ======================================================================
   stat_delta_accum #(.delta_t(cnt_t)) i_rx_pkts_stored (
      .clk(clk), .reset(reset), .inc(incs.rx_pkts_stored),
      .commit(commit[mac_grp_reg_pkg::idx_rx_pkts_stored]), .delta(deltas.rx_pkts_stored));
   stat_delta_accum #(.delta_t(cnt_t)) i_rx_pkts_dropped_full (
      .clk(clk), .reset(reset), .inc(incs.rx_pkts_dropped_full),
      .commit(commit[mac_grp_reg_pkg::idx_rx_pkts_dropped_full]),
      .delta(deltas.rx_pkts_dropped_full));
   stat_delta_accum #(.delta_t(cnt_t)) i_rx_pkts_dropped_bad (
      .clk(clk), .reset(reset), .inc(incs.rx_pkts_dropped_bad),
      .commit(commit[mac_grp_reg_pkg::idx_rx_pkts_dropped_bad]),
      .delta(deltas.rx_pkts_dropped_bad));
   stat_delta_accum #(.delta_t(cnt_t)) i_rx_pkts_dequeued (
      .clk(clk), .reset(reset), .inc(incs.rx_pkts_dequeued),
      .commit(commit[mac_grp_reg_pkg::idx_rx_pkts_dequeued]), .delta(deltas.rx_pkts_dequeued));
   stat_delta_accum #(.delta_t(byte_t)) i_rx_bytes_pushed (
      .clk(clk), .reset(reset), .inc(incs.rx_bytes_pushed),
      .commit(commit[mac_grp_reg_pkg::idx_rx_bytes_pushed]), .delta(deltas.rx_bytes_pushed));
   stat_delta_accum #(.delta_t(queue_t)) i_rx_pkts_in_queue (
      .clk(clk), .reset(reset), .inc(incs.rx_pkts_in_queue),
      .commit(commit[mac_grp_reg_pkg::idx_rx_pkts_in_queue]), .delta(deltas.rx_pkts_in_queue));
   stat_delta_accum #(.delta_t(cnt_t)) i_tx_pkts_enqueued (
      .clk(clk), .reset(reset), .inc(incs.tx_pkts_enqueued),
      .commit(commit[mac_grp_reg_pkg::idx_tx_pkts_enqueued]), .delta(deltas.tx_pkts_enqueued));
   stat_delta_accum #(.delta_t(cnt_t)) i_tx_pkts_sent (
      .clk(clk), .reset(reset), .inc(incs.tx_pkts_sent),
      .commit(commit[mac_grp_reg_pkg::idx_tx_pkts_sent]), .delta(deltas.tx_pkts_sent));
   stat_delta_accum #(.delta_t(byte_t)) i_tx_bytes_pushed (
      .clk(clk), .reset(reset), .inc(incs.tx_bytes_pushed),
      .commit(commit[mac_grp_reg_pkg::idx_tx_bytes_pushed]), .delta(deltas.tx_bytes_pushed));
   stat_delta_accum #(.delta_t(queue_t)) i_tx_pkts_in_queue (
      .clk(clk), .reset(reset), .inc(incs.tx_pkts_in_queue),
      .commit(commit[mac_grp_reg_pkg::idx_tx_pkts_in_queue]), .delta(deltas.tx_pkts_in_queue));

endmodule

// ==== logic/stat_scan_ctrl.sv ====
module stat_scan_ctrl (
   input  logic                                 clk,
   input  logic                                 reset,
   input  mac_grp_reg_pkg::apb_req_t            apb,
   output mac_grp_reg_pkg::data_t               prdata,
   output logic                                 pready,
   output logic                                 pslverr,
   input  mac_grp_stat_pkg::stat_deltas_t       deltas,
   output logic [mac_grp_reg_pkg::num_regs-1:0] commit,
   output logic                                 rf_we,
   output mac_grp_reg_pkg::reg_idx_t            rf_idx,
   output mac_grp_reg_pkg::data_t               rf_wdata,
   input  mac_grp_reg_pkg::data_t               rf_rdata,
   output logic                                 ctrl_load,
   output mac_grp_reg_pkg::data_t               ctrl_wdata
);

   typedef enum logic {st_sweep, st_scan} state_t;

   state_t                    state;
   mac_grp_reg_pkg::reg_idx_t scan_idx;
   mac_grp_reg_pkg::reg_idx_t word_idx;
   logic                      access;
   logic                      addr_ok;
   logic                      wr_ok;
   logic                      last_idx;
   mac_grp_reg_pkg::data_t    delta_ext;

   // ======================================================================
   // apb decode
   // ======================================================================
   assign access   = apb.psel && apb.penable;
   assign word_idx = apb.paddr[5:2];
   assign addr_ok  = (apb.paddr[1:0] == 2'b00) && (apb.paddr[7:6] == 2'b00) &&
                     (word_idx < mac_grp_reg_pkg::num_regs);

   // no wait states once the sweep is done
   assign pready     = access && (state == st_scan);
   assign pslverr    = pready && !addr_ok;
   assign prdata     = addr_ok ? rf_rdata : mac_grp_reg_pkg::bad_addr_data;
   assign wr_ok      = pready && apb.pwrite && addr_ok;
   assign ctrl_load  = wr_ok && (word_idx == mac_grp_reg_pkg::idx_control);
   assign ctrl_wdata = apb.pwdata;

   assign last_idx = (scan_idx == mac_grp_reg_pkg::reg_idx_t'(mac_grp_reg_pkg::num_regs - 1));

   // pending delta of the entry under the scanner, widened to a word
   always_comb begin
      case (scan_idx)
         mac_grp_reg_pkg::idx_rx_pkts_stored:
            delta_ext = mac_grp_reg_pkg::data_t'(deltas.rx_pkts_stored);
         mac_grp_reg_pkg::idx_rx_pkts_dropped_full:
            delta_ext = mac_grp_reg_pkg::data_t'(deltas.rx_pkts_dropped_full);
         mac_grp_reg_pkg::idx_rx_pkts_dropped_bad:
            delta_ext = mac_grp_reg_pkg::data_t'(deltas.rx_pkts_dropped_bad);
         mac_grp_reg_pkg::idx_rx_pkts_dequeued:
            delta_ext = mac_grp_reg_pkg::data_t'(deltas.rx_pkts_dequeued);
         mac_grp_reg_pkg::idx_rx_bytes_pushed:
            delta_ext = mac_grp_reg_pkg::data_t'(deltas.rx_bytes_pushed);
         mac_grp_reg_pkg::idx_rx_pkts_in_queue:
            delta_ext = mac_grp_reg_pkg::data_t'(deltas.rx_pkts_in_queue);
         mac_grp_reg_pkg::idx_tx_pkts_enqueued:
            delta_ext = mac_grp_reg_pkg::data_t'(deltas.tx_pkts_enqueued);
         mac_grp_reg_pkg::idx_tx_pkts_sent:
            delta_ext = mac_grp_reg_pkg::data_t'(deltas.tx_pkts_sent);
         mac_grp_reg_pkg::idx_tx_bytes_pushed:
            delta_ext = mac_grp_reg_pkg::data_t'(deltas.tx_bytes_pushed);
         mac_grp_reg_pkg::idx_tx_pkts_in_queue:
            delta_ext = mac_grp_reg_pkg::data_t'(deltas.tx_pkts_in_queue);
         default:
            delta_ext = '0;
      endcase
   end

   // ======================================================================
   // register file port
   // ======================================================================
   always_comb begin
      commit   = '0;
      rf_we    = 1'b1;
      rf_idx   = scan_idx;
      rf_wdata = '0;
      if (state == st_scan) begin
         if (access) begin
            rf_we    = wr_ok;
            rf_idx   = word_idx;
            rf_wdata = apb.pwdata;
         end else begin
            // read-modify-write of the scanned entry
            commit[scan_idx] = 1'b1;
            rf_wdata         = rf_rdata + delta_ext;
         end
      end
   end

   // sweep ignores the bus, scan pauses for it
   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= st_sweep;
         scan_idx <= '0;
      end else if (state == st_sweep || !access) begin
         scan_idx <= last_idx ? '0 : scan_idx + 1'b1;
         if (last_idx)
            state <= st_scan;
      end
   end

endmodule

// ==== logic/mac_ctrl_reg.sv ====
module mac_ctrl_reg (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       load,
   input  mac_grp_reg_pkg::data_t     wdata,
   output mac_grp_reg_pkg::mac_ctrl_t mac_ctrl
);

   mac_grp_reg_pkg::data_t                          ctrl_word;
   logic [mac_grp_reg_pkg::reset_stretch_cycles-1:0] reset_sr;

   always_ff @(posedge clk) begin
      if (reset)
         ctrl_word <= '0;
      else if (load)
         ctrl_word <= wdata;
   end

   // fills with ones during reset, drains after it
   always_ff @(posedge clk) begin
      reset_sr <= {reset_sr[mac_grp_reg_pkg::reset_stretch_cycles-2:0], reset};
   end

   // ======================================================================
   // control decode, disables in the word become active-high enables
   // ======================================================================
   always_comb begin
      mac_ctrl.reset_mac = ctrl_word[mac_grp_reg_pkg::bit_reset_mac] | (|reset_sr);
      mac_ctrl.disable_crc_check = ctrl_word[mac_grp_reg_pkg::bit_dis_crc_check];
      mac_ctrl.disable_crc_gen   = ctrl_word[mac_grp_reg_pkg::bit_dis_crc_gen];
      mac_ctrl.enable_jumbo_rx   = !ctrl_word[mac_grp_reg_pkg::bit_dis_jumbo_rx];
      mac_ctrl.enable_jumbo_tx   = !ctrl_word[mac_grp_reg_pkg::bit_dis_jumbo_tx];
      mac_ctrl.rx_mac_en         = !ctrl_word[mac_grp_reg_pkg::bit_disable_rx];
      mac_ctrl.tx_mac_en         = !ctrl_word[mac_grp_reg_pkg::bit_disable_tx];
      mac_ctrl.rx_queue_en       = !ctrl_word[mac_grp_reg_pkg::bit_rx_queue_disable];
      mac_ctrl.tx_queue_en       = !ctrl_word[mac_grp_reg_pkg::bit_tx_queue_disable];
   end

endmodule

// ==== logic/mac_grp_regs.sv ====
module mac_grp_regs (
   input  logic                         clk,
   input  logic                         reset,
   input  mac_grp_reg_pkg::apb_req_t    apb,
   output mac_grp_reg_pkg::data_t       prdata,
   output logic                         pready,
   output logic                         pslverr,
   input  mac_grp_stat_pkg::rx_events_t rx_events,
   input  mac_grp_stat_pkg::tx_events_t tx_events,
   output mac_grp_reg_pkg::mac_ctrl_t   mac_ctrl
);

   mac_grp_stat_pkg::stat_deltas_t        deltas;
   logic [mac_grp_reg_pkg::num_regs-1:0] commit;
   logic                                 rf_we;
   mac_grp_reg_pkg::reg_idx_t            rf_idx;
   mac_grp_reg_pkg::data_t               rf_wdata;
   mac_grp_reg_pkg::data_t               rf_rdata;
   logic                                 ctrl_load;
   mac_grp_reg_pkg::data_t               ctrl_wdata;

   stat_scan_ctrl i_stat_scan_ctrl (
      .clk        (clk),
      .reset      (reset),
      .apb        (apb),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .deltas     (deltas),
      .commit     (commit),
      .rf_we      (rf_we),
      .rf_idx     (rf_idx),
      .rf_wdata   (rf_wdata),
      .rf_rdata   (rf_rdata),
      .ctrl_load  (ctrl_load),
      .ctrl_wdata (ctrl_wdata)
   );

   stat_reg_file i_stat_reg_file (
      .clk   (clk),
      .we    (rf_we),
      .idx   (rf_idx),
      .wdata (rf_wdata),
      .rdata (rf_rdata)
   );

   stat_delta_bank i_stat_delta_bank (
      .clk       (clk),
      .reset     (reset),
      .rx_events (rx_events),
      .tx_events (tx_events),
      .commit    (commit),
      .deltas    (deltas)
   );

   mac_ctrl_reg i_mac_ctrl_reg (
      .clk      (clk),
      .reset    (reset),
      .load     (ctrl_load),
      .wdata    (ctrl_wdata),
      .mac_ctrl (mac_ctrl)
   );

endmodule

// ==== test/mac_grp_regs_chk.sv ====
module mac_grp_regs_chk (
   input logic                                 clk,
   input logic                                 reset,
   input mac_grp_reg_pkg::apb_req_t            apb,
   input logic                                 pready,
   input logic                                 pslverr,
   input mac_grp_reg_pkg::mac_ctrl_t           mac_ctrl,
   input logic [mac_grp_reg_pkg::num_regs-1:0] commit
);

   int unsigned assert_failures = 0;

   // error response only on a completed transfer
   a_err_with_ready: assert property (@(posedge clk) disable iff (reset) pslverr |-> pready)
      else begin assert_failures++; $error("pslverr high without pready"); end

   // ready only in an access phase
   a_ready_in_access: assert property (@(posedge clk) disable iff (reset)
      pready |-> (apb.psel && apb.penable))
      else begin assert_failures++; $error("pready high outside an access phase"); end

   // mac reset outlasts the block reset by the stretch length
   a_reset_stretch: assert property (@(posedge clk)
      $fell(reset) |-> mac_ctrl.reset_mac [*mac_grp_reg_pkg::reset_stretch_cycles]
                       ##1 !mac_ctrl.reset_mac)
      else begin assert_failures++; $error("reset_mac stretch has the wrong length"); end

   // scanner commits at most one entry
   a_commit_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(commit))
      else begin assert_failures++; $error("commit vector not one-hot or zero"); end

endmodule

// ==== test/mac_grp_regs_tb.sv ====
module mac_grp_regs_tb;

   localparam int unsigned half_period   = 4;
   localparam int unsigned reset_cycles  = 4;
   localparam int unsigned event_spacing = 8;
   localparam int unsigned quiet_cycles  = 64;
   localparam int unsigned ctrl_writes   = 16;
   localparam int unsigned stream_slots  = 200;
   localparam int unsigned clear_slots   = 100;
   localparam int unsigned bad_accesses  = 24;
   // event slots take about 2400 cycles, bus traffic under 1000 more
   localparam int unsigned timeout_cycles = 20000;

   logic                         clk;
   logic                         reset;
   mac_grp_reg_pkg::apb_req_t    apb;
   mac_grp_reg_pkg::data_t       prdata;
   logic                         pready;
   logic                         pslverr;
   mac_grp_stat_pkg::rx_events_t rx_events;
   mac_grp_stat_pkg::tx_events_t tx_events;
   mac_grp_reg_pkg::mac_ctrl_t   mac_ctrl;

   // expected register contents
   mac_grp_reg_pkg::data_t model [mac_grp_reg_pkg::num_regs];

   int unsigned cycle_count   = 0;
   int unsigned check_count   = 0;
   int unsigned error_count   = 0;
   int unsigned test_count    = 0;
   int unsigned failed_tests  = 0;
   int unsigned errors_before = 0;

   mac_grp_regs i_mac_grp_regs (
      .clk       (clk),
      .reset     (reset),
      .apb       (apb),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .rx_events (rx_events),
      .tx_events (tx_events),
      .mac_ctrl  (mac_ctrl)
   );

   bind mac_grp_regs mac_grp_regs_chk i_mac_grp_regs_chk (
      .clk      (clk),
      .reset    (reset),
      .apb      (apb),
      .pready   (pready),
      .pslverr  (pslverr),
      .mac_ctrl (mac_ctrl),
      .commit   (commit)
   );

   initial begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= timeout_cycles) begin
         $display("run stopped after %0d cycles, tests did not finish", cycle_count);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // ======================================================================
   // reference rules
   // ======================================================================
   function automatic logic addr_valid(input logic [7:0] addr);
      return (addr[1:0] == 2'b00) && (addr[7:6] == 2'b00) &&
             (addr[5:2] < mac_grp_reg_pkg::num_regs);
   endfunction

   function automatic logic [7:0] reg_addr(input int unsigned idx);
      return 8'(idx << 2);
   endfunction

   function automatic logic [7:0] random_bad_addr();
      logic [7:0] addr;
      addr = 8'($urandom);
      while (addr_valid(addr))
         addr = 8'($urandom);
      return addr;
   endfunction

   // disable bits in the word, enables on the outputs
   function automatic mac_grp_reg_pkg::mac_ctrl_t expected_ctrl(
      input mac_grp_reg_pkg::data_t word);
      mac_grp_reg_pkg::mac_ctrl_t exp;
      exp.reset_mac         = word[mac_grp_reg_pkg::bit_reset_mac];
      exp.disable_crc_check = word[mac_grp_reg_pkg::bit_dis_crc_check];
      exp.disable_crc_gen   = word[mac_grp_reg_pkg::bit_dis_crc_gen];
      exp.enable_jumbo_rx   = !word[mac_grp_reg_pkg::bit_dis_jumbo_rx];
      exp.enable_jumbo_tx   = !word[mac_grp_reg_pkg::bit_dis_jumbo_tx];
      exp.rx_mac_en         = !word[mac_grp_reg_pkg::bit_disable_rx];
      exp.tx_mac_en         = !word[mac_grp_reg_pkg::bit_disable_tx];
      exp.rx_queue_en       = !word[mac_grp_reg_pkg::bit_rx_queue_disable];
      exp.tx_queue_en       = !word[mac_grp_reg_pkg::bit_tx_queue_disable];
      return exp;
   endfunction

   task automatic check_data(input string name, input mac_grp_reg_pkg::data_t got,
                             input mac_grp_reg_pkg::data_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Error at %0t: %s got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_ctrl(input string name, input mac_grp_reg_pkg::mac_ctrl_t got,
                             input mac_grp_reg_pkg::mac_ctrl_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Error at %0t: %s got %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Error at %0t: %s got %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic finish_test(input string name);
      test_count++;
      if (error_count == errors_before) begin
         $display("test %0d %s: passed", test_count, name);
      end else begin
         failed_tests++;
         $display("test %0d %s: failed, %0d errors", test_count, name,
                  error_count - errors_before);
      end
      errors_before = error_count;
   endtask

   // ======================================================================
   // bus and event drivers
   // ======================================================================
   // setup, access until pready, then back to idle
   task automatic apb_transfer(input logic write, input logic [7:0] addr,
                               input mac_grp_reg_pkg::data_t wdata,
                               output mac_grp_reg_pkg::data_t rdata, output logic err,
                               output int unsigned waits);
      waits = 0;
      @(negedge clk);
      apb.psel    = 1'b1;
      apb.penable = 1'b0;
      apb.pwrite  = write;
      apb.paddr   = addr;
      apb.pwdata  = wdata;
      @(negedge clk);
      apb.penable = 1'b1;
      @(posedge clk);
      while (!pready) begin
         waits++;
         @(posedge clk);
      end
      rdata = prdata;
      err   = pslverr;
      @(negedge clk);
      apb = '0;
   endtask

   task automatic bus_access(input logic write, input logic [7:0] addr,
                             input mac_grp_reg_pkg::data_t wdata);
      mac_grp_reg_pkg::data_t rdata;
      logic                   err;
      int unsigned            waits;
      apb_transfer(write, addr, wdata, rdata, err, waits);
      // sweep is over, so pready comes in the first access cycle
      check_count++;
      if (waits != 0) begin
         error_count++;
         $display("transfer to address %h waited %0d cycles for pready", addr, waits);
      end
      check_bit("pslverr", err, !addr_valid(addr));
      if (!addr_valid(addr))
         check_data("prdata", rdata, mac_grp_reg_pkg::bad_addr_data);
      else if (write)
         model[addr[5:2]] = wdata;
      else
         check_data($sformatf("prdata[%0d]", addr[5:2]), rdata, model[addr[5:2]]);
   endtask

   task automatic check_all_regs();
      for (int unsigned i = 0; i < mac_grp_reg_pkg::num_regs; i++)
         bus_access(1'b0, reg_addr(i), '0);
   endtask

   task automatic add_events(input mac_grp_stat_pkg::rx_events_t rx,
                             input mac_grp_stat_pkg::tx_events_t tx);
      model[mac_grp_reg_pkg::idx_rx_pkts_stored]       += 32'(rx.pkt_good);
      model[mac_grp_reg_pkg::idx_rx_pkts_dropped_full] += 32'(rx.pkt_dropped);
      model[mac_grp_reg_pkg::idx_rx_pkts_dropped_bad]  += 32'(rx.pkt_bad);
      model[mac_grp_reg_pkg::idx_rx_pkts_dequeued]     += 32'(rx.pkt_pulled);
      if (rx.pkt_pulled)
         model[mac_grp_reg_pkg::idx_rx_bytes_pushed] += 32'(rx.pkt_byte_cnt);
      model[mac_grp_reg_pkg::idx_rx_pkts_in_queue] += 32'(rx.pkt_good) - 32'(rx.pkt_pulled);
      model[mac_grp_reg_pkg::idx_tx_pkts_enqueued] += 32'(tx.pkt_stored);
      model[mac_grp_reg_pkg::idx_tx_pkts_sent]     += 32'(tx.pkt_sent);
      if (tx.pkt_stored)
         model[mac_grp_reg_pkg::idx_tx_bytes_pushed] += 32'(tx.pkt_byte_cnt);
      model[mac_grp_reg_pkg::idx_tx_pkts_in_queue] += 32'(tx.pkt_stored) - 32'(tx.pkt_sent);
   endtask

   // flags may only rise in the first cycle of each slot
   task automatic run_event_slots(input int unsigned slots);
      mac_grp_stat_pkg::rx_events_t rx;
      mac_grp_stat_pkg::tx_events_t tx;
      for (int unsigned c = 0; c < slots * event_spacing; c++) begin
         rx = '0;
         tx = '0;
         rx.pkt_byte_cnt = 12'($urandom);
         tx.pkt_byte_cnt = 12'($urandom);
         if (c % event_spacing == 0) begin
            rx.pkt_good    = 1'($urandom);
            rx.pkt_bad     = 1'($urandom);
            rx.pkt_dropped = 1'($urandom);
            rx.pkt_pulled  = 1'($urandom);
            tx.pkt_sent    = 1'($urandom);
            tx.pkt_stored  = 1'($urandom);
         end
         @(negedge clk);
         rx_events = rx;
         tx_events = tx;
         add_events(rx, tx);
      end
      @(negedge clk);
      rx_events = '0;
      tx_events = '0;
      // more than two scanner laps
      repeat (quiet_cycles) @(negedge clk);
   endtask

   // ======================================================================
   // test sequence
   // ======================================================================
   initial begin
      mac_grp_reg_pkg::data_t rdata;
      logic                   err;
      int unsigned            waits;
      void'($urandom(32'h620e_1d08));
      reset     = 1'b1;
      apb       = '0;
      rx_events = '0;
      tx_events = '0;
      foreach (model[i])
         model[i] = '0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      check_bit("mac_ctrl.reset_mac", mac_ctrl.reset_mac, 1'b1);
      reset = 1'b0;

      apb_transfer(1'b0, reg_addr(mac_grp_reg_pkg::idx_control), '0, rdata, err, waits);
      if (waits == 0) begin
         error_count++;
         $display("first read after reset did not wait for the clearing sweep");
      end
      check_bit("pslverr", err, 1'b0);
      check_data("prdata[0]", rdata, '0);
      check_all_regs();
      check_ctrl("mac_ctrl", mac_ctrl, expected_ctrl('0));
      finish_test("reset state");

      for (int unsigned i = 0; i < ctrl_writes; i++) begin
         rdata = $urandom;
         bus_access(1'b1, reg_addr(mac_grp_reg_pkg::idx_control), rdata);
         check_ctrl("mac_ctrl", mac_ctrl, expected_ctrl(rdata));
         bus_access(1'b0, reg_addr(mac_grp_reg_pkg::idx_control), '0);
      end
      finish_test("control writes");

      run_event_slots(stream_slots);
      check_all_regs();
      finish_test("event stream");

      for (int unsigned i = 1; i < mac_grp_reg_pkg::num_regs; i++)
         bus_access(1'b1, reg_addr(i), '0);
      check_all_regs();
      run_event_slots(clear_slots);
      check_all_regs();
      finish_test("software clear");

      for (int unsigned i = 0; i < bad_accesses; i++)
         bus_access(1'($urandom), random_bad_addr(), $urandom);
      check_all_regs();
      check_ctrl("mac_ctrl", mac_ctrl, expected_ctrl(model[mac_grp_reg_pkg::idx_control]));
      finish_test("unmapped addresses");

      if (i_mac_grp_regs.i_mac_grp_regs_chk.assert_failures != 0) begin
         error_count += i_mac_grp_regs.i_mac_grp_regs_chk.assert_failures;
         $display("bound checker saw %0d assertion failures",
                  i_mac_grp_regs.i_mac_grp_regs_chk.assert_failures);
      end
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_count, failed_tests, check_count, error_count);
      if (error_count == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== filelist.f ====
logic/mac_grp_reg_pkg.sv
logic/mac_grp_stat_pkg.sv
logic/stat_delta_accum.sv
logic/stat_reg_file.sv
logic/stat_delta_bank.sv
logic/stat_scan_ctrl.sv
logic/mac_ctrl_reg.sv
logic/mac_grp_regs.sv
test/mac_grp_regs_chk.sv
test/mac_grp_regs_tb.sv

// ==== Bender.yml ====
package:
  name: mac_grp_regs

sources:
  - logic/mac_grp_reg_pkg.sv
  - logic/mac_grp_stat_pkg.sv
  - logic/stat_delta_accum.sv
  - logic/stat_reg_file.sv
  - logic/stat_delta_bank.sv
  - logic/stat_scan_ctrl.sv
  - logic/mac_ctrl_reg.sv
  - logic/mac_grp_regs.sv
  - target: test
    files:
      - test/mac_grp_regs_chk.sv
      - test/mac_grp_regs_tb.sv
